// ==== source/dunes_pkg.sv ====
`default_nettype none

package dunes_pkg;

    localparam int COORD_W = 11;

    typedef logic [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    typedef logic [1:0] level_t;

    localparam level_t LEVEL_ON = 2'd3;

    // Half-mound height profile, rising from the edge towards the peak
    function automatic logic [2:0] mound_profile(input logic [4:0] idx);
        logic [2:0] height;
        if (idx < 5'd6)
            height = 3'd0;
        else if (idx < 5'd9)
            height = 3'd1;
        else if (idx < 5'd13)
            height = 3'd2;
        else if (idx < 5'd16)
            height = 3'd3;
        else if (idx < 5'd19)
            height = 3'd4;
        else if (idx < 5'd22)
            height = 3'd5;
        else
            height = 3'd6;
        return height;
    endfunction

    localparam int CLOUD_W     = 20;
    localparam int CLOUD_H     = 8;
    localparam int CLOUD_SCALE = 2;

    typedef logic [CLOUD_W-1:0] cloud_row_t;

    // Leftmost sprite column sits in bit CLOUD_W-1
    localparam cloud_row_t CLOUD_ROWS [CLOUD_H] = '{
        20'b00000001111000000000,
        20'b00000111111100000000,
        20'b00011111111110000000,
        20'b00111111111111000000,
        20'b01111111111111100000,
        20'b00111111111111000000,
        20'b00011111111110000000,
        20'b00000111111100000000
    };

    localparam int NUM_STARS = 16;
    localparam int STAR_SIZE = 2;

    // y is the height of the star centre above the ground row
    localparam pixel_pos_t STAR_TABLE [NUM_STARS] = '{
        '{x: 11'd43,  y: 11'd480},
        '{x: 11'd176, y: 11'd480},
        '{x: 11'd246, y: 11'd440},
        '{x: 11'd328, y: 11'd424},
        '{x: 11'd432, y: 11'd408},
        '{x: 11'd483, y: 11'd392},
        '{x: 11'd672, y: 11'd376},
        '{x: 11'd634, y: 11'd352},
        '{x: 11'd160, y: 11'd568},
        '{x: 11'd208, y: 11'd552},
        '{x: 11'd400, y: 11'd536},
        '{x: 11'd576, y: 11'd520},
        '{x: 11'd624, y: 11'd504},
        '{x: 11'd768, y: 11'd552},
        '{x: 11'd848, y: 11'd472},
        '{x: 11'd968, y: 11'd456}
    };

endpackage

`default_nettype wire

// ==== source/dune_ground.sv ====
`timescale 1ns/1ps
`default_nettype none

module dune_ground #(
    parameter int H_RES    = 1024,
    parameter int GROUND_Y = 740
) (
    input  dunes_pkg::pixel_pos_t pos,
    input  dunes_pkg::coord_t     scroll,
    output logic                  ground_hit
);
    import dunes_pkg::*;

    localparam coord_t H_WRAP   = COORD_W'(H_RES);
    localparam coord_t GROUND_C = COORD_W'(GROUND_Y);
    localparam coord_t MOUND_X0 = 11'd306;
    localparam coord_t MOUND_W  = 11'd64;
    localparam coord_t HALF_W   = 11'd32;

    coord_t     mound_raw;
    coord_t     mound_x;
    logic       in_mound;
    logic [5:0] half_idx;
    logic [2:0] mound_h;
    coord_t     surf_y;
    coord_t     scroll_x;
    logic [2:0] res8;
    logic [3:0] res11;
    logic [4:0] res17;
    logic       dot_hit;

    // Mound scrolls with the ground, wrapped once into the visible width
    assign mound_raw = pos.x + scroll - MOUND_X0;
    assign mound_x   = (mound_raw >= H_WRAP) ? mound_raw - H_WRAP : mound_raw;
    assign in_mound  = (mound_x < MOUND_W);

    // Fold the right half back onto the left so both sides share the profile
    assign half_idx = (mound_x < HALF_W) ? mound_x[5:0] : 6'd63 - mound_x[5:0];
    assign mound_h  = mound_profile(half_idx[4:0]);
    assign surf_y   = in_mound ? GROUND_C - COORD_W'(mound_h) : GROUND_C;

    assign scroll_x = pos.x + scroll;
    assign res8     = scroll_x[2:0];
    assign res11    = 4'(scroll_x % 11'd11);
    assign res17    = 5'(scroll_x % 11'd17);

    // Three dot families at different depths under the surface
    assign dot_hit = ((res8 == 3'd2) && (pos.y == surf_y + 11'd3)) ||
                     ((res11 == 4'd4) && (pos.y == surf_y + 11'd5)) ||
                     ((res17 == 5'd9) && (pos.y == surf_y + 11'd7));

    assign ground_hit = (pos.y == surf_y) || dot_hit;

    always_comb
    begin
        if (in_mound)
        begin
            assert (half_idx < 6'd32)
            else $error("mound half index %0d out of profile range", half_idx);
        end
    end

endmodule

`default_nettype wire

// ==== source/cloud_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cloud_layer #(
    parameter int H_RES    = 1024,
    parameter int GROUND_Y = 740
) (
    input  dunes_pkg::pixel_pos_t pos,
    input  dunes_pkg::coord_t     scroll,
    output logic                  cloud_hit
);
    import dunes_pkg::*;

    localparam int     NUM_CLOUDS = 2;
    localparam coord_t H_WRAP     = COORD_W'(H_RES);
    localparam coord_t BOX_W      = COORD_W'(CLOUD_W * CLOUD_SCALE);
    localparam coord_t BOX_H      = COORD_W'(CLOUD_H * CLOUD_SCALE);

    localparam int CLOUD_X_BASE [NUM_CLOUDS] = '{280, 640};
    localparam int CLOUD_Y_OFF  [NUM_CLOUDS] = '{416, 480};

    logic [NUM_CLOUDS-1:0] hits;

    // Clouds drift left at half the ground speed
    for (genvar i = 0; i < NUM_CLOUDS; i++)
    begin : g_cloud
        localparam coord_t CY = COORD_W'(GROUND_Y - CLOUD_Y_OFF[i]);

        coord_t     cx_raw;
        coord_t     cx;
        logic       in_box;
        coord_t     local_x;
        coord_t     local_y;
        coord_t     sx;
        coord_t     sy;
        cloud_row_t row_bits;
        cloud_row_t shifted;

        assign cx_raw = COORD_W'(CLOUD_X_BASE[i]) + H_WRAP - (scroll >> 1);
        assign cx     = (cx_raw >= H_WRAP) ? cx_raw - H_WRAP : cx_raw;

        assign in_box = (pos.x >= cx) && (pos.x < cx + BOX_W) &&
                        (pos.y >= CY) && (pos.y < CY + BOX_H);

        assign local_x = pos.x - cx;
        assign local_y = pos.y - CY;
        assign sx      = local_x / COORD_W'(CLOUD_SCALE);
        assign sy      = local_y / COORD_W'(CLOUD_SCALE);

        assign row_bits = CLOUD_ROWS[sy[2:0]];
        // Column c lands in the top bit after shifting left by c
        assign shifted  = row_bits << sx[4:0];
        assign hits[i]  = in_box && shifted[CLOUD_W-1];

        always_comb
        begin
            if (in_box)
            begin
                assert (sy < COORD_W'(CLOUD_H))
                else $error("cloud %0d sprite row %0d past sprite height", i, sy);
            end
        end
    end

    assign cloud_hit = |hits;

endmodule

`default_nettype wire

// ==== source/star_field.sv ====
`timescale 1ns/1ps
`default_nettype none

module star_field #(
    parameter int GROUND_Y = 740
) (
    input  dunes_pkg::pixel_pos_t pos,
    input  dunes_pkg::coord_t     scroll,
    output logic                  star_hit
);
    import dunes_pkg::*;

    localparam coord_t ARM = COORD_W'(STAR_SIZE);

    logic                 twinkle;
    logic [NUM_STARS-1:0] hits;

    // Odd frames draw plus shapes, even frames diagonal crosses
    assign twinkle = scroll[0];

    for (genvar i = 0; i < NUM_STARS; i++)
    begin : g_star
        localparam coord_t CX = STAR_TABLE[i].x;
        localparam coord_t CY = COORD_W'(GROUND_Y) - STAR_TABLE[i].y;

        coord_t ax;
        coord_t ay;
        logic   plus_hit;
        logic   cross_hit;

        // Distances from the centre, kept unsigned
        assign ax = (pos.x >= CX) ? pos.x - CX : CX - pos.x;
        assign ay = (pos.y >= CY) ? pos.y - CY : CY - pos.y;

        assign plus_hit  = ((ax == '0) && (ay <= ARM)) ||
                           ((ay == '0) && (ax <= ARM));
        assign cross_hit = (ax == ay) && (ax <= ARM);

        assign hits[i] = twinkle ? plus_hit : cross_hit;
    end

    assign star_hit = |hits;

endmodule

`default_nettype wire

// ==== source/bg_pixel_dunes.sv ====
`timescale 1ns/1ps
`default_nettype none

module bg_pixel_dunes #(
    parameter int H_RES    = 1024,
    parameter int GROUND_Y = 740
) (
    input  logic              rst_n,
    input  logic              vsync,
    input  logic              bg_en,
    input  logic              video_active,
    input  dunes_pkg::coord_t pix_x,
    input  dunes_pkg::coord_t pix_y,
    output dunes_pkg::level_t R,
    output dunes_pkg::level_t G,
    output dunes_pkg::level_t B
);
    import dunes_pkg::*;

    pixel_pos_t pos;
    coord_t     scroll;
    logic       ground_hit;
    logic       cloud_hit;
    logic       star_hit;
    logic       any_hit;

    assign pos = '{x: pix_x, y: pix_y};

    // Frame counter, one step per vsync, wraps at 2048
    always_ff @(posedge vsync or negedge rst_n)
    begin
        if (!rst_n)
            scroll <= '0;
        else
            scroll <= scroll + 1'b1;
    end

    dune_ground #(
        .H_RES    (H_RES),
        .GROUND_Y (GROUND_Y)
    ) u_ground (
        .pos        (pos),
        .scroll     (scroll),
        .ground_hit (ground_hit)
    );

    cloud_layer #(
        .H_RES    (H_RES),
        .GROUND_Y (GROUND_Y)
    ) u_clouds (
        .pos       (pos),
        .scroll    (scroll),
        .cloud_hit (cloud_hit)
    );

    star_field #(
        .GROUND_Y (GROUND_Y)
    ) u_stars (
        .pos      (pos),
        .scroll   (scroll),
        .star_hit (star_hit)
    );

    assign any_hit = ground_hit || cloud_hit || star_hit;

    // Grey scale, one level on all three channels
    assign R = (video_active && bg_en && any_hit) ? LEVEL_ON : '0;
    assign G = R;
    assign B = R;

    assert property (@(posedge vsync) disable iff (!rst_n) !video_active |-> (R == '0))
    else $error("R is lit outside the active video area");

endmodule

`default_nettype wire

// ==== verif/bg_pixel_dunes_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bg_pixel_dunes_tb;
    import dunes_pkg::*;

    localparam int MAX_LINES  = 64;
    localparam int FIELDS     = 6;
    localparam int NUM_RANDOM = 16;
    localparam int SKY_ROWS   = 150;

    typedef struct packed {
        coord_t frame;
        coord_t x;
        coord_t y;
        logic   en;
        logic   active;
        level_t level;
    } trace_entry_t;

    logic   rst_n;
    logic   vsync;
    logic   bg_en;
    logic   video_active;
    coord_t pix_x;
    coord_t pix_y;
    level_t R;
    level_t G;
    level_t B;

    logic [COORD_W-1:0] trace_mem [MAX_LINES*FIELDS];
    trace_entry_t       entries [$];
    int                 frame;
    int                 max_frame;
    logic               loaded;
    logic [31:0]        lcg_state;

    bg_pixel_dunes #(
        .H_RES    (1024),
        .GROUND_Y (740)
    ) dut_i (
        .rst_n        (rst_n),
        .vsync        (vsync),
        .bg_en        (bg_en),
        .video_active (video_active),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .R            (R),
        .G            (G),
        .B            (B)
    );

    always #5 vsync = ~vsync;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Unused words keep all ones, so an all-ones frame field ends the trace
    task automatic load_trace();
        trace_entry_t e;
        int           i;
        int           n;
        for (i = 0; i < MAX_LINES*FIELDS; i++)
            trace_mem[i] = '1;
        $readmemh("verif/dunes_trace.txt", trace_mem);
        max_frame = 0;
        for (n = 0; n < MAX_LINES; n++)
        begin
            if (trace_mem[n*FIELDS] === '1)
                break;
            e.frame  = trace_mem[n*FIELDS];
            e.x      = trace_mem[n*FIELDS+1];
            e.y      = trace_mem[n*FIELDS+2];
            e.en     = trace_mem[n*FIELDS+3][0];
            e.active = trace_mem[n*FIELDS+4][0];
            e.level  = trace_mem[n*FIELDS+5][1:0];
            entries.push_back(e);
            if (int'(e.frame) > max_frame)
                max_frame = int'(e.frame);
        end
    endtask

    task automatic advance_to(input int target);
        while (frame < target)
        begin
            @(posedge vsync);
            frame++;
            #1;
        end
    endtask

    task automatic check_level(input string name, input level_t actual, input level_t expected);
        assert (actual === expected)
        else
        begin
            $display("[FAIL] t=%0t %s expected %0d, got %0d", $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "pixel level mismatch");
        end
    endtask

    // Several pixels fit in one frame, half a nanosecond each
    task automatic apply_pixel(input coord_t x, input coord_t y, input logic en,
                               input logic active, input level_t expected);
        pix_x        = x;
        pix_y        = y;
        bg_en        = en;
        video_active = active;
        #0.25;
        check_level("R", R, expected);
        check_level("G", G, expected);
        check_level("B", B, expected);
        #0.25;
    endtask

    initial
    begin
        trace_entry_t e;
        coord_t       rx;
        coord_t       ry;
        int           n;
        rst_n        = 1'b0;
        vsync        = 1'b0;
        bg_en        = 1'b0;
        video_active = 1'b0;
        pix_x        = '0;
        pix_y        = '0;
        frame        = 0;
        loaded       = 1'b0;
        lcg_state    = 32'd18220;
        load_trace();
        if (entries.size() == 0)
        begin
            $display("Trace file verif/dunes_trace.txt held no pixel checks");
            $display("SIMULATION FAILED");
            $fatal(1, "no stimulus");
        end
        loaded = 1'b1;
        repeat (3) @(posedge vsync);
        #1;
        rst_n = 1'b1;
        foreach (entries[i])
        begin
            e = entries[i];
            advance_to(int'(e.frame));
            apply_pixel(e.x, e.y, e.en, e.active, e.level);
        end
        // Sky rows above every star, cloud and ground row stay dark
        for (n = 0; n < NUM_RANDOM; n++)
        begin
            advance_to(frame + 1);
            lcg_state = lcg_next(lcg_state);
            rx        = coord_t'(lcg_state[25:16]);
            lcg_state = lcg_next(lcg_state);
            ry        = coord_t'(lcg_state[30:16] % SKY_ROWS);
            apply_pixel(rx, ry, 1'b1, 1'b1, '0);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    initial
    begin
        wait (loaded);
        #((max_frame + NUM_RANDOM + 20) * 10);
        $display("Watchdog expired before all pixel checks completed");
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== verif/dunes_trace.txt ====
// frame pix_x pix_y bg_en video_active level, all in hex
// Frame counts are vsync edges after reset release, in ascending order
// Ground row away from the mound, then raised surface at mound positions 10, 20 and 40
000 064 2E4 1 1 3
000 064 2E5 1 1 0
000 13C 2E2 1 1 3
000 13C 2E4 1 1 0
000 146 2DF 1 1 3
000 15A 2DE 1 1 3
// Clouds at their base positions
000 126 14C 1 1 3
000 118 144 1 1 0
000 294 10A 1 1 3
000 284 104 1 1 0
// Star 0 plus arm, diagonal and centre on an odd frame
001 02D 104 1 1 3
001 02C 105 1 1 0
001 02B 104 1 1 3
// Star 0 on an even frame
002 02D 104 1 1 0
002 02C 105 1 1 3
// Dot families mod 8, 11 and 17, each next to a wrong residue
005 1F5 2E7 1 1 3
005 1F6 2E7 1 1 0
005 1F9 2E9 1 1 3
005 1FA 2E9 1 1 0
005 202 2EB 1 1 3
005 203 2EB 1 1 0
// Clouds shifted left by 20
028 112 14C 1 1 3
028 126 14C 1 1 0
028 280 10A 1 1 3
028 294 10A 1 1 0
// Output gates on a lit ground pixel
028 064 2E4 1 1 3
028 064 2E4 0 1 0
028 064 2E4 1 0 0

// ==== files.f ====
source/dunes_pkg.sv
source/dune_ground.sv
source/cloud_layer.sv
source/star_field.sv
source/bg_pixel_dunes.sv
verif/bg_pixel_dunes_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = bg_pixel_dunes_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
